// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_wb_async_mem
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/async_mem_settings.svh ====
`ifndef ASYNC_MEM_SETTINGS_SVH
`define ASYNC_MEM_SETTINGS_SVH

// ---------------------------------------------------------------------------
// wishbone side
// ---------------------------------------------------------------------------

`define WB_AW 32
`define WB_DW 32
`define WB_SW 4

// ---------------------------------------------------------------------------
// device side
// ---------------------------------------------------------------------------

// 16-bit device bus, byte mode only uses dq[7:0]
`define MEM_DW 16
`define MEM_AW 24

// each wait phase field and the wait counter
`define TMR_W 4

`endif

// ==== verif/sram_model.sv ====
`include "async_mem_settings.svh"
`timescale 1ns/100ps

module sram_model
  import async_mem_pkg::*;
(
  input  logic               clk_i,
  input  sram_pins_t         pins_i,
  output logic [`MEM_DW-1:0] dq_o
);

  localparam int DEPTH = 1024;

  logic [`MEM_DW-1:0] mem [0:DEPTH-1];
  logic [9:0]         idx;
  logic [`MEM_DW-1:0] word;

  assign idx  = pins_i.addr[9:0];
  assign word = mem[idx];

  // odd multiplier keeps every address bit in the pattern
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = 16'(i * 32'h9e37) ^ 16'h3c5a;
  end

  // cell follows the bus while we_n is low, sampled away from the clock edge
  always @(negedge clk_i)
  begin
    if (!pins_i.ce_n && !pins_i.we_n && pins_i.dq_oe)
    begin
      if (!pins_i.lb_n)
        mem[idx][7:0] = pins_i.dq_o[7:0];
      if (!pins_i.ub_n)
        mem[idx][15:8] = pins_i.dq_o[15:8];
    end
  end

  // bus resolution, device drives only when the controller does not
  always_comb
  begin
    dq_o = '0;
    if (!pins_i.ce_n && !pins_i.oe_n && !pins_i.dq_oe)
    begin
      if (!pins_i.lb_n)
        dq_o[7:0] = word[7:0];
      if (!pins_i.ub_n)
        dq_o[15:8] = word[15:8];
    end
  end

endmodule

// ==== verif/tb_wb_async_mem.sv ====
`include "async_mem_settings.svh"
`timescale 1ns/100ps

module tb_wb_async_mem
  import async_mem_pkg::*;
();

  localparam int MAX_CYCLES = 4000;

  logic               clk;
  logic               rst;
  wb_req_t            wb_req;
  logic               wb_stb;
  logic               wb_cyc;
  logic [`WB_DW-1:0]  wb_dat;
  logic               wb_ack;
  mem_timing_t        timing;
  logic               big_endian;
  logic               lo_byte;
  sram_pins_t         pins;
  logic [`MEM_DW-1:0] dq;

  logic [31:0] ref_mem [0:255];
  logic [3:0]  part_sel [0:5] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
  int          seed = 32'h0cbb_14b3;
  int          errors = 0;
  int          mon_errors = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cycle_cnt = 0;
  int          ce_run = 0;
  int          we_run = 0;
  int          oe_run = 0;
  int          mark;
  logic        rst_q = 1'b1;

  wb_async_mem DUT (
    .wb_hi_clk_i  (clk),
    .wb_hi_rst_i  (rst),
    .wb_req_i     (wb_req),
    .wb_stb_i     (wb_stb),
    .wb_cyc_i     (wb_cyc),
    .wb_dat_o     (wb_dat),
    .wb_ack_o     (wb_ack),
    .timing_i     (timing),
    .big_endian_i (big_endian),
    .lo_byte_i    (lo_byte),
    .pins_o       (pins),
    .dq_i         (dq)
  );

  sram_model u_sram_model (
    .clk_i  (clk),
    .pins_i (pins),
    .dq_o   (dq)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // --------------------------------------------------------------------------
  // reference helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] byte_reverse(input logic [31:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  function automatic int chunk_count(input logic lo, input logic [3:0] sel);
    if (lo)
      return (sel == 4'b1111) ? 4 : ((sel == 4'b0011 || sel == 4'b1100) ? 2 : 1);
    return int'(|sel[1:0]) + int'(|sel[3:2]);
  endfunction

  function automatic int chunk_len();
    return int'(timing.ce_setup) + int'(timing.op_hold) + int'(timing.ce_hold);
  endfunction

  function automatic int total_errors();
    return errors + mon_errors;
  endfunction

  // --------------------------------------------------------------------------
  // bus driver
  // --------------------------------------------------------------------------

  task automatic set_config(input logic lo, input logic be, input logic [3:0] s,
                            input logic [3:0] h, input logic [3:0] k);
    @(posedge clk);
    lo_byte    <= lo;
    big_endian <= be;
    timing     <= '{ce_setup: s, op_hold: h, ce_hold: k};
  endtask

  task automatic wb_access(input logic [31:0] addr, input logic [31:0] data,
                           input logic we, input logic [3:0] sel, output logic [31:0] rdat);
    int         cycles;
    int         want;
    logic [3:0] lane_sel;
    cycles = 0;
    @(posedge clk);
    wb_req <= '{adr: addr, dat: data, we: we, sel: sel};
    wb_stb <= 1'b1;
    wb_cyc <= 1'b1;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!wb_ack);
    rdat = wb_dat;
    // one idle cycle plus the three phases for every chunk
    lane_sel = big_endian ? {sel[0], sel[1], sel[2], sel[3]} : sel;
    want = chunk_count(lo_byte, lane_sel) * (chunk_len() + 1);
    assert (cycles == want)
    else
    begin
      $display("Mismatch wb_ack_o latency: got 0x%h, expected 0x%h", cycles, want);
      errors++;
    end
    @(posedge clk);
    wb_stb <= 1'b0;
    wb_cyc <= 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] sel);
    logic [31:0] rd_ignored;
    logic [31:0] lane_dat;
    logic [3:0]  lane_sel;
    wb_access(addr, data, 1'b1, sel, rd_ignored);
    lane_dat = big_endian ? byte_reverse(data) : data;
    lane_sel = big_endian ? {sel[0], sel[1], sel[2], sel[3]} : sel;
    for (int b = 0; b < 4; b++)
      if (lane_sel[b])
        ref_mem[addr[9:2]][8*b +: 8] = lane_dat[8*b +: 8];
  endtask

  task automatic read_check(input logic [31:0] addr);
    logic [31:0] got;
    logic [31:0] want;
    wb_access(addr, 32'h0, 1'b0, 4'b1111, got);
    want = big_endian ? byte_reverse(ref_mem[addr[9:2]]) : ref_mem[addr[9:2]];
    assert (got === want)
    else
    begin
      $display("Mismatch wb_dat_o at 0x%h: got 0x%h, expected 0x%h", addr, got, want);
      errors++;
    end
  endtask

  // byte mode and halfword mode round trip under one timing setting
  task automatic strobe_round(input logic [3:0] s, input logic [3:0] h,
                              input logic [3:0] k, input int idx);
    set_config(1'b1, 1'b0, s, h, k);
    wb_write(32'h180 + 4*idx, $random(seed), 4'b1111);
    read_check(32'h180 + 4*idx);
    set_config(1'b0, 1'b0, s, h, k);
    wb_write(32'hc0 + 4*idx, $random(seed), 4'b1111);
    read_check(32'hc0 + 4*idx);
  endtask

  task automatic end_test(input string name, input int start_errors);
    // let the pin monitor close the strobe runs of the last access
    @(negedge clk);
    @(posedge clk);
    if (total_errors() == start_errors)
    begin
      pass_cnt++;
      $display("test %s: pass", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: fail with %0d errors", name, total_errors() - start_errors);
    end
  endtask

  // --------------------------------------------------------------------------
  // pin monitor
  // --------------------------------------------------------------------------

  task automatic check_run(input string name, input logic strobe_n, inout int run,
                           input int want);
    if (!strobe_n)
      run++;
    else if (run != 0)
    begin
      assert (run == want)
      else
      begin
        $display("Mismatch %s low cycles: got 0x%h, expected 0x%h", name, run, want);
        mon_errors++;
      end
      run = 0;
    end
  endtask

  always @(negedge clk)
  begin
    if (rst || rst_q)
    begin
      assert (!wb_ack && pins.ce_n && pins.we_n && pins.oe_n)
      else
      begin
        $display("Error: ack or a device strobe is active around reset");
        mon_errors++;
      end
    end
    assert (pins.we_n || pins.oe_n)
    else
    begin
      $display("Error: we_n and oe_n are low in the same cycle");
      mon_errors++;
    end
    assert (!pins.dq_oe || (wb_stb && wb_cyc && wb_req.we))
    else
    begin
      $display("Error: dq_oe is high without a write request");
      mon_errors++;
    end
    if (rst)
    begin
      ce_run = 0;
      we_run = 0;
      oe_run = 0;
    end
    else
    begin
      check_run("ce_n", pins.ce_n, ce_run, chunk_len());
      check_run("we_n", pins.we_n, we_run, int'(timing.op_hold));
      check_run("oe_n", pins.oe_n, oe_run, int'(timing.op_hold));
    end
    rst_q = rst;
  end

  initial
  begin
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial
  begin
    // a read request held through reset must not start the device
    rst        = 1'b1;
    wb_req     = '{adr: 32'h0, dat: 32'h0, we: 1'b0, sel: 4'b1111};
    wb_stb     = 1'b1;
    wb_cyc     = 1'b1;
    big_endian = 1'b0;
    lo_byte    = 1'b0;
    timing     = '{ce_setup: 4'd1, op_hold: 4'd2, ce_hold: 4'd1};

    mark = total_errors();
    repeat (5) @(posedge clk);
    rst    <= 1'b0;
    wb_stb <= 1'b0;
    wb_cyc <= 1'b0;
    repeat (2) @(negedge clk);
    end_test("reset", mark);

    mark = total_errors();
    set_config(1'b0, 1'b0, 4'd1, 4'd2, 4'd1);
    for (int i = 0; i < 8; i++)
      wb_write(32'h40 + 4*i, $random(seed), 4'b1111);
    for (int i = 0; i < 8; i++)
      read_check(32'h40 + 4*i);
    end_test("halfword_full_words", mark);

    mark = total_errors();
    set_config(1'b1, 1'b0, 4'd1, 4'd2, 4'd1);
    for (int i = 0; i < 4; i++)
      wb_write(32'h100 + 4*i, $random(seed), 4'b1111);
    for (int k = 0; k < 6; k++)
      wb_write(32'h100 + 4*(k % 4), $random(seed), part_sel[k]);
    for (int i = 0; i < 4; i++)
      read_check(32'h100 + 4*i);
    end_test("byte_partial_selects", mark);

    mark = total_errors();
    set_config(1'b0, 1'b1, 4'd1, 4'd2, 4'd1);
    wb_write(32'h80, $random(seed), 4'b1111);
    wb_write(32'h84, $random(seed), 4'b1111);
    wb_write(32'h84, $random(seed), 4'b1000);
    set_config(1'b0, 1'b0, 4'd1, 4'd2, 4'd1);
    wb_write(32'h88, $random(seed), 4'b1111);
    // swapped on write only, so this one comes back reversed
    read_check(32'h80);
    read_check(32'h88);
    set_config(1'b0, 1'b1, 4'd1, 4'd2, 4'd1);
    read_check(32'h84);
    end_test("endian_swap", mark);

    mark = total_errors();
    strobe_round(4'd0, 4'd1, 4'd0, 0);
    strobe_round(4'd2, 4'd3, 4'd1, 1);
    strobe_round(4'd1, 4'd4, 4'd0, 2);
    end_test("strobe_timing", mark);

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             pass_cnt, fail_cnt, total_errors());
    if (fail_cnt == 0 && total_errors() == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog/async_mem_pkg.sv ====
`include "async_mem_settings.svh"

package async_mem_pkg;

  typedef struct packed {
    logic [`WB_AW-1:0]  adr;
    logic [`WB_DW-1:0]  dat;
    logic               we;
    logic [`WB_SW-1:0]  sel;
  } wb_req_t;

  // one device chunk, adr is still a byte address
  typedef struct packed {
    logic [`WB_AW-1:0]  adr;
    logic [`MEM_DW-1:0] dat;
    logic               we;
    logic [1:0]         sel;
  } lo_req_t;

  typedef struct packed {
    logic [`TMR_W-1:0]  ce_setup;
    logic [`TMR_W-1:0]  op_hold;
    logic [`TMR_W-1:0]  ce_hold;
  } mem_timing_t;

  // lanes of the 32-bit word served by the current chunk
  typedef struct packed {
    logic [3:0]         byte_en;
    logic [1:0]         word_en;
    logic               rd;
  } chunk_info_t;

  typedef struct packed {
    logic [`MEM_AW-1:0] addr;
    logic [`MEM_DW-1:0] dq_o;
    logic               dq_oe;
    logic               ub_n;
    logic               lb_n;
    logic               we_n;
    logic               ce_n;
    logic               oe_n;
  } sram_pins_t;

endpackage

// ==== verilog/read_assembler.sv ====
`include "async_mem_settings.svh"
`timescale 1ns/100ps

module read_assembler
  import async_mem_pkg::*;
(
  input  logic               wb_hi_clk_i,
  input  chunk_info_t        chunk_i,
  input  logic [`MEM_DW-1:0] rd_data_i,
  output logic [`WB_DW-1:0]  wb_dat_o
);

  logic [7:0]       rd_lo;
  logic [7:0]       rd_hi;
  logic [3:0]       lane_en;
  logic [`WB_DW-1:0] rd_buf;

  // byte mode feeds every lane from dq[7:0]
  assign rd_lo = rd_data_i[7:0];
  assign rd_hi = (|chunk_i.word_en) ? rd_data_i[15:8] : rd_data_i[7:0];

  // ------------------------------------------------------------------------
  // per byte buffer and bypass
  // ------------------------------------------------------------------------

  for (genvar i = 0; i < 4; i++)
  begin : g_lane
    logic [7:0] src;

    assign lane_en[i] = (chunk_i.byte_en[i] || chunk_i.word_en[i/2]) && chunk_i.rd;

    // odd lanes take the upper device byte
    assign src = (i % 2 == 1) ? rd_hi : rd_lo;

    always_ff @(posedge wb_hi_clk_i)
    begin
      if (lane_en[i])
        rd_buf[8*i +: 8] <= src;
    end

    // last chunk shows up together with the ack
    assign wb_dat_o[8*i +: 8] = lane_en[i] ? src : rd_buf[8*i +: 8];
  end

endmodule

// ==== verilog/sram_timing_ctrl.sv ====
`include "async_mem_settings.svh"
`timescale 1ns/100ps

module sram_timing_ctrl
  import async_mem_pkg::*;
(
  input  logic               wb_hi_clk_i,
  input  logic               wb_hi_rst_i,
  input  logic               req_valid_i,
  input  logic               lo_byte_i,
  input  lo_req_t            lo_req_i,
  input  mem_timing_t        timing_i,
  input  logic [`MEM_DW-1:0] dq_i,
  output logic               chunk_ack_o,
  output logic [`MEM_DW-1:0] rd_data_o,
  output sram_pins_t         pins_o
);

  localparam logic [3:0] ST_IDLE     = 4'b0001;
  localparam logic [3:0] ST_CE_SETUP = 4'b0010;
  localparam logic [3:0] ST_OP_HOLD  = 4'b0100;
  localparam logic [3:0] ST_CE_HOLD  = 4'b1000;

  logic [3:0]         state;
  logic [3:0]         next_state;
  logic [`TMR_W-1:0]  cnt;
  logic [`TMR_W-1:0]  cnt_mux;
  logic               zero_setup;
  logic               zero_hold;
  logic               wait_cnt;
  logic               op_phase;
  logic [`MEM_DW-1:0] dq_buf;

  assign zero_setup = (timing_i.ce_setup == '0);
  assign zero_hold  = (timing_i.ce_hold == '0);
  assign wait_cnt   = (cnt != '0);
  assign op_phase   = (state == ST_OP_HOLD);

  // ------------------------------------------------------------------------
  // wait phase FSM
  // ------------------------------------------------------------------------

  always_ff @(posedge wb_hi_clk_i or posedge wb_hi_rst_i)
  begin
    if (wb_hi_rst_i)
      state <= ST_IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      ST_IDLE:
        if (req_valid_i)
          next_state = zero_setup ? ST_OP_HOLD : ST_CE_SETUP;
      ST_CE_SETUP:
        if (!wait_cnt)
          next_state = ST_OP_HOLD;
      ST_OP_HOLD:
        if (!wait_cnt)
          next_state = zero_hold ? ST_IDLE : ST_CE_HOLD;
      ST_CE_HOLD:
        if (!wait_cnt)
          next_state = ST_IDLE;
      default:
        next_state = ST_IDLE;
    endcase
  end

  // counter reloads with the length of the phase being entered
  always_comb
  begin
    case (next_state)
      ST_CE_SETUP: cnt_mux = timing_i.ce_setup;
      ST_OP_HOLD:  cnt_mux = timing_i.op_hold;
      ST_CE_HOLD:  cnt_mux = timing_i.ce_hold;
      default:     cnt_mux = '0;
    endcase
  end

  always_ff @(posedge wb_hi_clk_i or posedge wb_hi_rst_i)
  begin
    if (wb_hi_rst_i)
      cnt <= '0;
    else if (state != next_state)
      cnt <= cnt_mux - 1'b1;
    else
      cnt <= cnt - 1'b1;
  end

  assign chunk_ack_o = (op_phase && !wait_cnt && zero_hold) ||
                       (state == ST_CE_HOLD && !wait_cnt);

  // ------------------------------------------------------------------------
  // read capture
  // ------------------------------------------------------------------------

  always_ff @(posedge wb_hi_clk_i)
  begin
    if (op_phase)
      dq_buf <= dq_i;
  end

  // no ce hold means the chunk ends in op hold, so take dq live
  assign rd_data_o = (op_phase && zero_hold) ? dq_i : dq_buf;

  // ------------------------------------------------------------------------
  // pins
  // ------------------------------------------------------------------------

  assign pins_o.addr  = lo_byte_i ? lo_req_i.adr[`MEM_AW-1:0] : lo_req_i.adr[`MEM_AW:1];
  assign pins_o.dq_o  = lo_req_i.dat;
  assign pins_o.dq_oe = lo_req_i.we;
  assign pins_o.ub_n  = !lo_req_i.sel[1];
  assign pins_o.lb_n  = !lo_req_i.sel[0];
  assign pins_o.we_n  = !(lo_req_i.we && op_phase);
  assign pins_o.oe_n  = !(!lo_req_i.we && op_phase);
  assign pins_o.ce_n  = !(req_valid_i && state != ST_IDLE);

endmodule

// ==== verilog/wb_async_mem.sv ====
`include "async_mem_settings.svh"
`timescale 1ns/100ps

module wb_async_mem
  import async_mem_pkg::*;
(
  input  logic               wb_hi_clk_i,
  input  logic               wb_hi_rst_i,
  input  wb_req_t            wb_req_i,
  input  logic               wb_stb_i,
  input  logic               wb_cyc_i,
  output logic [`WB_DW-1:0]  wb_dat_o,
  output logic               wb_ack_o,
  input  mem_timing_t        timing_i,
  input  logic               big_endian_i,
  input  logic               lo_byte_i,
  output sram_pins_t         pins_o,
  input  logic [`MEM_DW-1:0] dq_i
);

  wb_req_t            req_sw;
  logic               req_valid;
  lo_req_t            lo_req;
  chunk_info_t        chunk;
  logic               chunk_ack;
  logic [`MEM_DW-1:0] rd_data;
  logic [`WB_DW-1:0]  rd_word;

  assign req_valid = wb_stb_i && wb_cyc_i;

  // ------------------------------------------------------------------------
  // endian lane swap, bytes of both data paths and the select bits
  // ------------------------------------------------------------------------

  assign req_sw.adr = wb_req_i.adr;
  assign req_sw.we  = wb_req_i.we;
  assign req_sw.dat = big_endian_i ? {<<8{wb_req_i.dat}} : wb_req_i.dat;
  assign req_sw.sel = big_endian_i ? {<<{wb_req_i.sel}} : wb_req_i.sel;
  assign wb_dat_o   = big_endian_i ? {<<8{rd_word}} : rd_word;

  wb_size_bridge u_size_bridge (
    .wb_hi_clk_i (wb_hi_clk_i),
    .wb_hi_rst_i (wb_hi_rst_i),
    .wb_req_i    (req_sw),
    .req_valid_i (req_valid),
    .lo_byte_i   (lo_byte_i),
    .chunk_ack_i (chunk_ack),
    .lo_req_o    (lo_req),
    .chunk_o     (chunk),
    .wb_ack_o    (wb_ack_o)
  );

  read_assembler u_read_asm (
    .wb_hi_clk_i (wb_hi_clk_i),
    .chunk_i     (chunk),
    .rd_data_i   (rd_data),
    .wb_dat_o    (rd_word)
  );

  sram_timing_ctrl u_timing (
    .wb_hi_clk_i (wb_hi_clk_i),
    .wb_hi_rst_i (wb_hi_rst_i),
    .req_valid_i (req_valid),
    .lo_byte_i   (lo_byte_i),
    .lo_req_i    (lo_req),
    .timing_i    (timing_i),
    .dq_i        (dq_i),
    .chunk_ack_o (chunk_ack),
    .rd_data_o   (rd_data),
    .pins_o      (pins_o)
  );

endmodule

// ==== verilog/wb_size_bridge.sv ====
`include "async_mem_settings.svh"
`timescale 1ns/100ps

module wb_size_bridge
  import async_mem_pkg::*;
(
  input  logic        wb_hi_clk_i,
  input  logic        wb_hi_rst_i,
  input  wb_req_t     wb_req_i,
  input  logic        req_valid_i,
  input  logic        lo_byte_i,
  input  logic        chunk_ack_i,
  output lo_req_t     lo_req_o,
  output chunk_info_t chunk_o,
  output logic        wb_ack_o
);

  localparam logic [3:0] ST_PASS  = 4'b0001;
  localparam logic [3:0] ST_MORE1 = 4'b0010;
  localparam logic [3:0] ST_MORE2 = 4'b0100;
  localparam logic [3:0] ST_MORE3 = 4'b1000;

  logic       more3;
  logic       more1;
  logic [3:0] state;
  logic [3:0] next_state;
  logic [3:0] byte_en;
  logic [1:0] word_en;
  logic [1:0] byte_lane;
  logic [1:0] lane;
  logic [1:0] dev_sel;
  logic [7:0] wr_lo;
  logic [7:0] wr_hi;
  logic       all_done;

  // chunks beyond the first one
  always_comb
  begin
    more3 = 1'b0;
    more1 = 1'b0;
    if (lo_byte_i)
    begin
      if (wb_req_i.sel == 4'b1111)
        more3 = 1'b1;
      else if (wb_req_i.sel == 4'b0011 || wb_req_i.sel == 4'b1100)
        more1 = 1'b1;
    end
    else if (wb_req_i.sel == 4'b1111)
      more1 = 1'b1;
  end

  // ------------------------------------------------------------------------
  // chunk sequencer
  // ------------------------------------------------------------------------

  always_ff @(posedge wb_hi_clk_i or posedge wb_hi_rst_i)
  begin
    if (wb_hi_rst_i)
      state <= ST_PASS;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      ST_PASS:
        if (chunk_ack_i && req_valid_i)
          next_state = more3 ? ST_MORE3 : (more1 ? ST_MORE1 : ST_PASS);
      ST_MORE3:
        if (chunk_ack_i)
          next_state = ST_MORE2;
      ST_MORE2:
        if (chunk_ack_i)
          next_state = ST_MORE1;
      ST_MORE1:
        if (chunk_ack_i)
          next_state = ST_PASS;
      default:
        next_state = ST_PASS;
    endcase
  end

  // byte mode lane per chunk, lower lane first
  always_comb
  begin
    byte_en = 4'b0000;
    if (lo_byte_i)
    begin
      case (wb_req_i.sel)
        4'b0001, 4'b0010, 4'b0100, 4'b1000:
          if (state == ST_PASS)
            byte_en = wb_req_i.sel;
        4'b0011:
          if (state == ST_PASS)
            byte_en = 4'b0001;
          else if (state == ST_MORE1)
            byte_en = 4'b0010;
        4'b1100:
          if (state == ST_PASS)
            byte_en = 4'b0100;
          else if (state == ST_MORE1)
            byte_en = 4'b1000;
        4'b1111:
          byte_en = {state[1], state[2], state[3], state[0]};
        default:
          byte_en = 4'b0000;
      endcase
    end
  end

  // halfword mode, one chunk per half touched
  always_comb
  begin
    word_en = 2'b00;
    if (!lo_byte_i)
    begin
      case (wb_req_i.sel)
        4'b0001, 4'b0010, 4'b0011:
          word_en = {1'b0, state == ST_PASS};
        4'b0100, 4'b1000, 4'b1100:
          word_en = {state == ST_PASS, 1'b0};
        4'b1111:
          word_en = {state == ST_MORE1, state == ST_PASS};
        default:
          word_en = 2'b00;
      endcase
    end
  end

  always_comb
  begin
    case (byte_en)
      4'b0010: byte_lane = 2'd1;
      4'b0100: byte_lane = 2'd2;
      4'b1000: byte_lane = 2'd3;
      default: byte_lane = 2'd0;
    endcase
  end

  assign lane = lo_byte_i ? byte_lane : {word_en[1], 1'b0};

  // single byte in halfword mode sets only its strobe
  always_comb
  begin
    dev_sel = 2'b11;
    if (!lo_byte_i && state == ST_PASS)
    begin
      case (wb_req_i.sel)
        4'b0001, 4'b0100: dev_sel = 2'b01;
        4'b0010, 4'b1000: dev_sel = 2'b10;
        default:          dev_sel = 2'b11;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------------

  assign wr_lo = wb_req_i.dat[{lane, 3'b000} +: 8];
  assign wr_hi = word_en[1] ? wb_req_i.dat[31:24] : wb_req_i.dat[15:8];

  assign all_done = (!(more3 || more1) && state == ST_PASS) ||
                    ((more3 || more1) && state == ST_MORE1);

  assign wb_ack_o = all_done && req_valid_i && chunk_ack_i;

  assign lo_req_o.adr = {wb_req_i.adr[`WB_AW-1:2], lane};
  assign lo_req_o.dat = {wr_hi, wr_lo};
  assign lo_req_o.we  = wb_req_i.we && req_valid_i;
  assign lo_req_o.sel = dev_sel;

  assign chunk_o.byte_en = byte_en;
  assign chunk_o.word_en = word_en;
  assign chunk_o.rd      = !wb_req_i.we && req_valid_i;

endmodule

// ==== vlog.f ====
+incdir+include
verilog/async_mem_pkg.sv
verilog/wb_size_bridge.sv
verilog/read_assembler.sv
verilog/sram_timing_ctrl.sv
verilog/wb_async_mem.sv
verif/sram_model.sv
verif/tb_wb_async_mem.sv
